//--- flist.f
+incdir+verif
src/tcp_pkg.sv
src/tcp_seg_if.sv
src/tcp_seg_latch.sv
src/tcp_send_pacer.sv
src/tcp_conn_ctrl.sv
src/tcp_server_top.sv
verif/tb_tcp_server.sv

//--- run.sh
#!/bin/bash
# Build and run the TCP server testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -sv --assert --top-module tb_tcp_server -f flist.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_tcp_server)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1

//--- src/tcp_conn_ctrl.sv
`timescale 1ns/1ps

module tcp_conn_ctrl import tcp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	tcp_seg_if.ctrl     seg,

	// From pacer and transmit side
	input  logic        wdat_start_i,
	input  logic        wdat_lock_i,
	input  logic        tcp_wdat_stop_i,
	input  logic        trnsmt_busy_i,
	input  tcp_len_t    ram_dat_len_i,

	// Outgoing header
	output logic        cmd_start_o,
	output tcp_flags_t  tcp_flags_o,
	output tcp_seq_t    tcp_seq_num_o,
	output tcp_seq_t    tcp_ack_num_o,
	output tcp_port_t   tcp_dest_port_o,
	output tcp_len_t    tcp_data_len_o,

	// Status
	output tcp_seq_t    snd_seq_o,
	output logic        established_o,
	output logic        listen_o,
	output tcp_flags_t  rcv_flags_o,
	output tcp_seq_t    rcv_ack_num_o
);

	tcp_state_e state;

	logic syn_ev;
	logic ack_ev;
	logic fin_ev;
	logic rst_ev;
	logic psh_ev;

	logic listen_syn;
	logic listen_ack;
	logic data_ack;
	logic est_fin;
	logic wdat_stop;

	// ----------------------------------------
	// Consume and event decode
	// ----------------------------------------
	// Wait while a reply or data start is due, or tx busy
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			seg.consume <= 1'b0;
		else if (seg.consume)
			seg.consume <= 1'b0;
		else if (seg.full && !cmd_start_o && !wdat_start_i && !trnsmt_busy_i &&
			state != CLOSE_WAIT)
			seg.consume <= 1'b1;
	end

	assign syn_ev = seg.consume && seg.flags[FLAG_SYN];
	assign ack_ev = seg.consume && seg.flags[FLAG_ACK];
	assign fin_ev = seg.consume && seg.flags[FLAG_FIN];
	assign rst_ev = seg.consume && seg.flags[FLAG_RST];
	assign psh_ev = seg.consume && seg.flags[FLAG_PSH];

	// Qualified per state
	assign listen_syn = syn_ev && !ack_ev && state == LISTEN;
	assign listen_ack = ack_ev && state == LISTEN;
	assign data_ack   = psh_ev && ack_ev && !fin_ev && !rst_ev && state == ESTABLISHED;
	assign est_fin    = fin_ev && state == ESTABLISHED;
	// Data packet finished
	assign wdat_stop  = tcp_wdat_stop_i && wdat_lock_i;

	// ----------------------------------------
	// Connection FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= LISTEN;
		else
		begin
			case (state)
				LISTEN:
					if (listen_syn)
						state <= SYN_RCVD;
				SYN_RCVD:
					if (rst_ev)
						state <= LISTEN;
					else if (syn_ev)
						state <= CLOSED;
					else if (ack_ev)
						state <= ESTABLISHED;
				ESTABLISHED:
					if (rst_ev)
						state <= CLOSED;
					else if (fin_ev)
						state <= CLOSE_WAIT;
				// FIN+ACK goes out from here
				CLOSE_WAIT:
					state <= LAST_ACK;
				LAST_ACK:
					if (rst_ev || ack_ev)
						state <= CLOSED;
				CLOSED:
					state <= LISTEN;
				default:
					state <= LISTEN;
			endcase
		end
	end

	// Header-only reply start, one cycle after its cause
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cmd_start_o <= 1'b0;
		else if (cmd_start_o)
			cmd_start_o <= 1'b0;
		else if (listen_syn || listen_ack || data_ack || state == CLOSE_WAIT)
			cmd_start_o <= 1'b1;
	end

	// ----------------------------------------
	// Outgoing header registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_flags_o <= '0;
		else if (listen_ack)
			tcp_flags_o <= FLAGS_RST_ACK;
		else if (listen_syn)
			tcp_flags_o <= FLAGS_SYN_ACK;
		else if (wdat_start_i)
			tcp_flags_o <= FLAGS_PSH_ACK;
		else if (data_ack)
			tcp_flags_o <= FLAGS_ACK;
		else if (state == CLOSE_WAIT)
			tcp_flags_o <= FLAGS_FIN_ACK;
	end

	// Send sequence number
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_seq_num_o <= TCP_ISS;
		else if (listen_ack)
			tcp_seq_num_o <= seg.ack;
		else if (listen_syn)
			tcp_seq_num_o <= TCP_ISS;
		else if (ack_ev && state == SYN_RCVD)
			tcp_seq_num_o <= tcp_seq_num_o + 32'd1;
		else if (wdat_stop && state == ESTABLISHED)
			tcp_seq_num_o <= tcp_seq_num_o + {16'd0, ram_dat_len_i};
	end

	// Acknowledge number
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_ack_num_o <= '0;
		else if (listen_ack)
			tcp_ack_num_o <= seg.seq;
		else if (listen_syn || est_fin)
			tcp_ack_num_o <= seg.seq + 32'd1;
		else if (data_ack)
			tcp_ack_num_o <= seg.seq + {16'd0, seg.len};
	end

	// Payload length, zero for control replies
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_data_len_o <= '0;
		else if (wdat_start_i)
			tcp_data_len_o <= ram_dat_len_i;
		else if (listen_syn || listen_ack || data_ack || est_fin)
			tcp_data_len_o <= '0;
	end

	// Peer port, taken whenever no connection owns it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_dest_port_o <= '0;
		else if (listen_syn || listen_ack)
			tcp_dest_port_o <= seg.src_port;
	end

	// Status outputs
	assign snd_seq_o     = tcp_seq_num_o;
	assign established_o = state == ESTABLISHED;
	assign listen_o      = state == LISTEN;
	assign rcv_flags_o   = seg.flags;
	assign rcv_ack_num_o = seg.ack;

	// Reply and data packet never share a cycle
	a_one_start: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(cmd_start_o && wdat_start_i)
	) else $error("reply and data start together");

endmodule

//--- src/tcp_pkg.sv
package tcp_pkg;

	// ----------------------------------------
	// Header field types
	// ----------------------------------------
	typedef logic [31:0] tcp_seq_t;
	typedef logic [15:0] tcp_len_t;
	typedef logic [15:0] tcp_port_t;
	typedef logic [15:0] tcp_win_t;
	// URG ACK PSH RST SYN FIN, bit 5 down to 0
	typedef logic [5:0]  tcp_flags_t;
	// Header length in 32-bit words
	typedef logic [3:0]  tcp_hlen_t;

	// Connection states, passive open only
	typedef enum logic [2:0] {
		LISTEN,
		SYN_RCVD,
		ESTABLISHED,
		CLOSE_WAIT,
		LAST_ACK,
		CLOSED
	} tcp_state_e;

	// Flag bit positions
	localparam int FLAG_FIN = 0;
	localparam int FLAG_SYN = 1;
	localparam int FLAG_RST = 2;
	localparam int FLAG_PSH = 3;
	localparam int FLAG_ACK = 4;

	// Reply flag codes
	localparam tcp_flags_t FLAGS_SYN_ACK = 6'h12;
	localparam tcp_flags_t FLAGS_ACK     = 6'h10;
	localparam tcp_flags_t FLAGS_PSH_ACK = 6'h18;
	localparam tcp_flags_t FLAGS_FIN_ACK = 6'h11;
	localparam tcp_flags_t FLAGS_RST_ACK = 6'h14;
	localparam tcp_flags_t FLAGS_RST     = 6'h04;

	// Server side constants
	localparam tcp_port_t LOCAL_PORT      = 16'd63256;
	localparam tcp_seq_t  TCP_ISS         = 32'd0;
	localparam tcp_hlen_t TCP_HEAD_LEN    = 4'd5;
	// Peer window must exceed this before data goes out
	localparam tcp_seq_t  SEND_WINDOW_MIN = 32'd25000;

endpackage

//--- src/tcp_seg_if.sv
`timescale 1ns/1ps

interface tcp_seg_if import tcp_pkg::*; ();

	// Buffer occupied
	logic       full;
	// Latched header fields
	tcp_flags_t flags;
	tcp_seq_t   seq;
	tcp_seq_t   ack;
	tcp_len_t   len;
	tcp_win_t   win;
	tcp_port_t  src_port;
	// One-cycle consume pulse from the controller
	logic       consume;

	modport latch (output full, flags, seq, ack, len, win, src_port, input consume);

	modport ctrl (input full, flags, seq, ack, len, win, src_port, output consume);

	// Window tracking only needs ack and window
	modport pacer (input full, ack, win, consume);

endinterface

//--- src/tcp_seg_latch.sv
`timescale 1ns/1ps

module tcp_seg_latch import tcp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// Offered segment
	input  logic        seg_valid_i,
	input  tcp_port_t   seg_src_port_i,
	input  tcp_flags_t  seg_flags_i,
	input  tcp_seq_t    seg_seq_i,
	input  tcp_seq_t    seg_ack_i,
	input  tcp_len_t    seg_len_i,
	input  tcp_win_t    seg_win_i,
	output logic        seg_rd_o,

	// Held segment towards controller and pacer
	tcp_seg_if.latch    seg
);

	logic take;

	// ----------------------------------------
	// Accept only into an empty buffer
	// ----------------------------------------
	assign take     = seg_valid_i && !seg.full;
	// Read strobe back to the source, same cycle
	assign seg_rd_o = take;

	// Occupancy flag
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			seg.full <= 1'b0;
		else if (take)
			seg.full <= 1'b1;
		else if (seg.consume)
			seg.full <= 1'b0;
	end

	// Header fields, loaded on accept
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			seg.flags    <= seg_flags_i;
			seg.seq      <= seg_seq_i;
			seg.ack      <= seg_ack_i;
			seg.len      <= seg_len_i;
			seg.win      <= seg_win_i;
			seg.src_port <= seg_src_port_i;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	// Controller consumes only a held segment
	a_consume_when_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		seg.consume |-> seg.full
	) else $error("segment consumed while buffer empty");

endmodule

//--- src/tcp_send_pacer.sv
`timescale 1ns/1ps

module tcp_send_pacer import tcp_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// Held segment, window fields only
	tcp_seg_if.pacer  seg,

	// From controller
	input  tcp_seq_t  snd_seq_i,
	input  logic      established_i,
	input  logic      cmd_start_i,

	// Transmit side
	input  logic      data_rdy_i,
	input  logic      trnsmt_busy_i,
	input  logic      tcp_wdat_stop_i,

	output logic      wdat_start_o,
	output logic      wdat_lock_o
);

	tcp_seq_t eff_win;
	logic     send_ok;

	// ----------------------------------------
	// Effective peer window
	// ----------------------------------------
	// Right edge of peer window minus our next seq
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			eff_win <= '0;
		else if (!established_i)
			eff_win <= '0;
		else if (seg.consume)
			eff_win <= seg.ack + {16'd0, seg.win} - snd_seq_i;
	end

	// All send conditions in one term
	assign send_ok = established_i && data_rdy_i && !trnsmt_busy_i && !seg.full &&
		!cmd_start_i && !wdat_lock_o && (eff_win > SEND_WINDOW_MIN);

	// ----------------------------------------
	// Start pulse and lock
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wdat_start_o <= 1'b0;
		else if (wdat_start_o)
			wdat_start_o <= 1'b0;
		else if (send_ok)
			wdat_start_o <= 1'b1;
	end

	// Held until the encoder reports the packet done
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wdat_lock_o <= 1'b0;
		else if (!established_i || tcp_wdat_stop_i)
			wdat_lock_o <= 1'b0;
		else if (wdat_start_o)
			wdat_lock_o <= 1'b1;
	end

	// One packet in flight at a time
	a_no_start_locked: assert property (
		@(posedge clk) disable iff (!rst_n)
		wdat_lock_o |-> !wdat_start_o
	) else $error("data start while send lock held");

endmodule

//--- src/tcp_server_top.sv
`timescale 1ns/1ps

module tcp_server_top import tcp_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// Received segment
	input  logic        seg_valid_i,
	input  tcp_port_t   seg_src_port_i,
	input  tcp_flags_t  seg_flags_i,
	input  tcp_seq_t    seg_seq_i,
	input  tcp_seq_t    seg_ack_i,
	input  tcp_len_t    seg_len_i,
	input  tcp_win_t    seg_win_i,
	output logic        seg_rd_o,

	// Transmit buffer and encoder
	input  logic        data_rdy_i,
	input  tcp_len_t    ram_dat_len_i,
	input  logic        trnsmt_busy_i,
	input  logic        tcp_wdat_stop_i,

	// Outgoing header
	output logic        ctrl_cmd_start_o,
	output logic        tcp_wdat_start_o,
	output tcp_flags_t  tcp_flags_o,
	output tcp_seq_t    tcp_seq_num_o,
	output tcp_seq_t    tcp_ack_num_o,
	output tcp_port_t   tcp_dest_port_o,
	output tcp_port_t   tcp_source_port_o,
	output tcp_hlen_t   tcp_head_len_o,
	output tcp_len_t    tcp_data_len_o,

	// Status
	output logic        tcp_state_listen_o,
	output logic        tcp_state_estblsh_o,
	output tcp_flags_t  rcv_flags_o,
	output tcp_seq_t    rcv_ack_num_o,
	output logic        tcp_new_pckt_rcv_o
);

	logic     wdat_lock;
	tcp_seq_t snd_seq;

	tcp_seg_if seg_bus ();

	// ----------------------------------------
	// Segment buffer and send pacing
	// ----------------------------------------
	tcp_seg_latch u_seg_latch (
		.clk            (clk),
		.rst_n          (rst_n),
		.seg_valid_i    (seg_valid_i),
		.seg_src_port_i (seg_src_port_i),
		.seg_flags_i    (seg_flags_i),
		.seg_seq_i      (seg_seq_i),
		.seg_ack_i      (seg_ack_i),
		.seg_len_i      (seg_len_i),
		.seg_win_i      (seg_win_i),
		.seg_rd_o       (seg_rd_o),
		.seg            (seg_bus.latch)
	);

	tcp_send_pacer u_send_pacer (
		.clk             (clk),
		.rst_n           (rst_n),
		.seg             (seg_bus.pacer),
		.snd_seq_i       (snd_seq),
		.established_i   (tcp_state_estblsh_o),
		.cmd_start_i     (ctrl_cmd_start_o),
		.data_rdy_i      (data_rdy_i),
		.trnsmt_busy_i   (trnsmt_busy_i),
		.tcp_wdat_stop_i (tcp_wdat_stop_i),
		.wdat_start_o    (tcp_wdat_start_o),
		.wdat_lock_o     (wdat_lock)
	);

	// Connection FSM and header
	tcp_conn_ctrl u_conn_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.seg             (seg_bus.ctrl),
		.wdat_start_i    (tcp_wdat_start_o),
		.wdat_lock_i     (wdat_lock),
		.tcp_wdat_stop_i (tcp_wdat_stop_i),
		.trnsmt_busy_i   (trnsmt_busy_i),
		.ram_dat_len_i   (ram_dat_len_i),
		.cmd_start_o     (ctrl_cmd_start_o),
		.tcp_flags_o     (tcp_flags_o),
		.tcp_seq_num_o   (tcp_seq_num_o),
		.tcp_ack_num_o   (tcp_ack_num_o),
		.tcp_dest_port_o (tcp_dest_port_o),
		.tcp_data_len_o  (tcp_data_len_o),
		.snd_seq_o       (snd_seq),
		.established_o   (tcp_state_estblsh_o),
		.listen_o        (tcp_state_listen_o),
		.rcv_flags_o     (rcv_flags_o),
		.rcv_ack_num_o   (rcv_ack_num_o)
	);

	// Fixed header fields
	assign tcp_source_port_o  = LOCAL_PORT;
	assign tcp_head_len_o     = TCP_HEAD_LEN;
	assign tcp_new_pckt_rcv_o = seg_bus.consume;

endmodule

//--- verif/tb_tcp_vectors.svh
`ifndef TB_TCP_VECTORS_SVH
`define TB_TCP_VECTORS_SVH

// How each row is applied
localparam int MODE_REPLY  = 0;
localparam int MODE_SILENT = 1;
localparam int MODE_SEND   = 2;
localparam int MODE_BUSY   = 3;

localparam int NUM_VECS = 8;

typedef struct {
	string      name;
	tcp_flags_t flags;
	tcp_seq_t   seq;
	tcp_seq_t   ack;
	tcp_len_t   len;
	tcp_win_t   win;
	int         mode;
	tcp_flags_t exp_flags;
	tcp_seq_t   exp_seq;
	tcp_seq_t   exp_ack;
	logic       exp_listen;
	logic       exp_estab;
} vec_t;

// Peer ISN 1000, one data packet of SEND_LEN bytes sent after row 2
localparam tcp_len_t SEND_LEN = 16'd200;

`endif

//--- verif/tb_tcp_server.sv
`timescale 1ns/1ps

module tb_tcp_server import tcp_pkg::*; ();

	`include "tb_tcp_vectors.svh"

	localparam int TIMEOUT_CYC = 100;
	localparam tcp_port_t PEER_PORT = 16'd40000;

	logic       clk;
	logic       rst_n;
	logic       seg_valid_i;
	tcp_port_t  seg_src_port_i;
	tcp_flags_t seg_flags_i;
	tcp_seq_t   seg_seq_i;
	tcp_seq_t   seg_ack_i;
	tcp_len_t   seg_len_i;
	tcp_win_t   seg_win_i;
	logic       seg_rd_o;
	logic       data_rdy_i;
	tcp_len_t   ram_dat_len_i;
	logic       trnsmt_busy_i;
	logic       tcp_wdat_stop_i;
	logic       ctrl_cmd_start_o;
	logic       tcp_wdat_start_o;
	tcp_flags_t tcp_flags_o;
	tcp_seq_t   tcp_seq_num_o;
	tcp_seq_t   tcp_ack_num_o;
	tcp_port_t  tcp_dest_port_o;
	tcp_port_t  tcp_source_port_o;
	tcp_hlen_t  tcp_head_len_o;
	tcp_len_t   tcp_data_len_o;
	logic       tcp_state_listen_o;
	logic       tcp_state_estblsh_o;
	tcp_flags_t rcv_flags_o;
	tcp_seq_t   rcv_ack_num_o;
	logic       tcp_new_pckt_rcv_o;

	vec_t  vecs [NUM_VECS];
	string cur_name;
	bit    test_err;
	bit    timed_out;
	bit    ok;
	int    pass_count;
	int    fail_count;

	tcp_server_top u_tcp_server_top (.*);

	always #5 clk = ~clk;

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic check_val(input string field, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v)
		begin
			$display("FAILED %s %s: expected %0h actual %0h", cur_name, field, exp_v, act_v);
			test_err = 1;
		end
	endtask

	// One result line per test
	task automatic report_test();
		if (test_err)
		begin
			$display("FAIL %s", cur_name);
			fail_count++;
		end
		else
		begin
			$display("PASS %s", cur_name);
			pass_count++;
		end
	endtask

	// Read strobe is combinational, stable in the low half
	task automatic wait_seg_rd(output bit found);
		int n;
		found = 0;
		for (n = 0; n < TIMEOUT_CYC; n++)
		begin
			#1;
			if (seg_rd_o)
			begin
				found = 1;
				break;
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_reply(output bit found);
		int n;
		found = 0;
		for (n = 0; n < TIMEOUT_CYC; n++)
		begin
			@(negedge clk);
			if (ctrl_cmd_start_o)
			begin
				found = 1;
				break;
			end
		end
	endtask

	task automatic wait_consume(output bit found);
		int n;
		found = 0;
		for (n = 0; n < TIMEOUT_CYC; n++)
		begin
			@(negedge clk);
			if (tcp_new_pckt_rcv_o)
			begin
				found = 1;
				break;
			end
		end
	endtask

	task automatic wait_data_start(output bit found);
		int n;
		found = 0;
		for (n = 0; n < TIMEOUT_CYC; n++)
		begin
			@(negedge clk);
			if (tcp_wdat_start_o)
			begin
				found = 1;
				break;
			end
		end
	endtask

	// Expected values follow the reply rules, seq numbers in our send space
	task automatic load_vectors();
		vecs[0] = '{"syn_listen", 6'h02, 32'd1000, 32'd0, 16'd0, 16'd0, MODE_REPLY,
			FLAGS_SYN_ACK, TCP_ISS, 32'd1001, 1'b0, 1'b0};
		vecs[1] = '{"ack_handshake", 6'h10, 32'd1001, 32'd1, 16'd0, 16'd30000, MODE_SILENT,
			6'h00, 32'd0, 32'd0, 1'b0, 1'b1};
		vecs[2] = '{"psh_then_send", 6'h18, 32'd1001, 32'd1, 16'd100, 16'd30000, MODE_SEND,
			FLAGS_ACK, TCP_ISS + 32'd1, 32'd1101, 1'b0, 1'b1};
		vecs[3] = '{"ack_after_send", 6'h18, 32'd1101, 32'd201, 16'd50, 16'd30000, MODE_REPLY,
			FLAGS_ACK, TCP_ISS + 32'd1 + 32'(SEND_LEN), 32'd1151, 1'b0, 1'b1};
		vecs[4] = '{"busy_hold", 6'h18, 32'd1151, 32'd201, 16'd10, 16'd30000, MODE_BUSY,
			FLAGS_ACK, TCP_ISS + 32'd1 + 32'(SEND_LEN), 32'd1161, 1'b0, 1'b1};
		vecs[5] = '{"fin_close", 6'h11, 32'd1161, 32'd201, 16'd0, 16'd30000, MODE_REPLY,
			FLAGS_FIN_ACK, TCP_ISS + 32'd1 + 32'(SEND_LEN), 32'd1162, 1'b0, 1'b0};
		vecs[6] = '{"last_ack", 6'h10, 32'd1162, 32'd202, 16'd0, 16'd30000, MODE_SILENT,
			6'h00, 32'd0, 32'd0, 1'b1, 1'b0};
		vecs[7] = '{"ack_listen", 6'h10, 32'd5000, 32'd7777, 16'd0, 16'd100, MODE_REPLY,
			FLAGS_RST_ACK, 32'd7777, 32'd5000, 1'b1, 1'b0};
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		clk             = 0;
		rst_n           = 0;
		seg_valid_i     = 0;
		seg_src_port_i  = PEER_PORT;
		seg_flags_i     = '0;
		seg_seq_i       = '0;
		seg_ack_i       = '0;
		seg_len_i       = '0;
		seg_win_i       = '0;
		data_rdy_i      = 0;
		ram_dat_len_i   = SEND_LEN;
		trnsmt_busy_i   = 0;
		tcp_wdat_stop_i = 0;
		pass_count      = 0;
		fail_count      = 0;
		timed_out       = 0;
		load_vectors();

		repeat (10) @(negedge clk);
		rst_n = 1;
		repeat (2) @(negedge clk);

		// Idle after reset
		cur_name = "reset_state";
		test_err = 0;
		check_val("listen", 32'd1, 32'(tcp_state_listen_o));
		check_val("estab", 32'd0, 32'(tcp_state_estblsh_o));
		check_val("cmd_start", 32'd0, 32'(ctrl_cmd_start_o));
		check_val("data_start", 32'd0, 32'(tcp_wdat_start_o));
		check_val("new_pckt", 32'd0, 32'(tcp_new_pckt_rcv_o));
		check_val("seg_rd", 32'd0, 32'(seg_rd_o));
		report_test();

		for (int i = 0; i < NUM_VECS; i++)
		begin
			cur_name    = vecs[i].name;
			test_err    = 0;
			// Offer the segment
			seg_flags_i = vecs[i].flags;
			seg_seq_i   = vecs[i].seq;
			seg_ack_i   = vecs[i].ack;
			seg_len_i   = vecs[i].len;
			seg_win_i   = vecs[i].win;
			seg_valid_i = 1;
			if (vecs[i].mode == MODE_BUSY)
				trnsmt_busy_i = 1;
			wait_seg_rd(ok);
			if (!ok)
			begin
				$display("TIMEOUT %s: segment never taken", cur_name);
				timed_out = 1;
				break;
			end
			@(negedge clk);
			seg_valid_i = 0;

			// Back-pressure, no start of either kind
			if (vecs[i].mode == MODE_BUSY)
			begin
				repeat (20)
				begin
					@(negedge clk);
					if (ctrl_cmd_start_o || tcp_wdat_start_o)
					begin
						$display("%s: start pulse while transmitter busy", cur_name);
						test_err = 1;
					end
				end
				trnsmt_busy_i = 0;
			end

			if (vecs[i].mode == MODE_SILENT)
			begin
				wait_consume(ok);
				if (!ok)
				begin
					$display("TIMEOUT %s: segment never consumed", cur_name);
					timed_out = 1;
					break;
				end
				repeat (5)
				begin
					@(negedge clk);
					if (ctrl_cmd_start_o)
					begin
						$display("%s: unexpected reply", cur_name);
						test_err = 1;
					end
				end
			end
			else
			begin
				wait_reply(ok);
				if (!ok)
				begin
					$display("TIMEOUT %s: no reply start", cur_name);
					timed_out = 1;
					break;
				end
				check_val("flags", 32'(vecs[i].exp_flags), 32'(tcp_flags_o));
				check_val("seq", vecs[i].exp_seq, tcp_seq_num_o);
				check_val("ack", vecs[i].exp_ack, tcp_ack_num_o);
				// Header-only replies carry no payload
				check_val("reply_len", 32'd0, 32'(tcp_data_len_o));
				check_val("dest_port", 32'(PEER_PORT), 32'(tcp_dest_port_o));
				check_val("src_port", 32'(LOCAL_PORT), 32'(tcp_source_port_o));
				check_val("head_len", 32'(TCP_HEAD_LEN), 32'(tcp_head_len_o));
			end
			// Latched segment as offered
			check_val("rcv_flags", 32'(vecs[i].flags), 32'(rcv_flags_o));
			check_val("rcv_ack", vecs[i].ack, rcv_ack_num_o);
			check_val("listen", 32'(vecs[i].exp_listen), 32'(tcp_state_listen_o));
			check_val("estab", 32'(vecs[i].exp_estab), 32'(tcp_state_estblsh_o));

			// One data packet from the transmit buffer
			if (vecs[i].mode == MODE_SEND)
			begin
				data_rdy_i = 1;
				wait_data_start(ok);
				if (!ok)
				begin
					$display("TIMEOUT %s: no data start", cur_name);
					timed_out = 1;
					break;
				end
				data_rdy_i = 0;
				// Header registers load on the start cycle
				@(negedge clk);
				check_val("data_flags", 32'(FLAGS_PSH_ACK), 32'(tcp_flags_o));
				check_val("data_len", 32'(SEND_LEN), 32'(tcp_data_len_o));
				repeat (3) @(negedge clk);
				tcp_wdat_stop_i = 1;
				@(negedge clk);
				tcp_wdat_stop_i = 0;
				@(negedge clk);
			end

			report_test();
		end

		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && !timed_out && !test_err)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
